// ==== common/dcache_pkg.sv ====
package dcache_pkg;

	localparam int WORDS_PER_LINE = 4;
	localparam int HALVES_PER_LINE = 8;
	localparam int INDEX_W_DEFAULT = 6;
	localparam int TAG_W = 32 - INDEX_W_DEFAULT - 4;	// word and byte offsets take 4 bits
	localparam int LINE_ADDR_W = 30;

	typedef logic [31:0] word_t;
	typedef logic [3:0] be_t;

	// word 0 and half 0 both sit at the top of the line
	typedef union packed {
		word_t [0:WORDS_PER_LINE-1] words;			// cache view
		logic [0:HALVES_PER_LINE-1][15:0] halves;	// memory view
	} line_u;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [INDEX_W_DEFAULT-1:0] index;
		logic [1:0] word_off;
		logic [1:0] byte_off;
	} cache_addr_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		logic [TAG_W-1:0] tag;
	} way_flags_t;

	typedef struct packed {
		way_flags_t [1:0] way;
		logic lru;	// way to replace next
	} flag_line_t;

	typedef struct packed {
		cache_addr_t addr;
		word_t wdata;
		be_t be;
		logic rd;
		logic wr;
	} req_t;

	// line_addr is the word address of word 0, low two bits zero
	typedef struct packed {
		logic [LINE_ADDR_W-1:0] line_addr;
		logic wr;
		line_u wline;
	} mem_req_t;

	typedef enum logic [2:0] {
		IDLE,
		CHECK,
		DONE,
		EVICT,
		LOAD,
		LOAD2
	} ctrl_state_t;

endpackage

// ==== dcache/dcache_arrays.sv ====
`timescale 1ns/10ps

module dcache_arrays #(
	parameter int INDEX_W = dcache_pkg::INDEX_W_DEFAULT
) (
	input logic clk_50m,
	input logic rst_n,
	input logic en,
	input logic rd,
	input logic wr_data,
	input logic wr_flag,
	input logic [INDEX_W-1:0] index,
	input dcache_pkg::flag_line_t flag_in,
	input dcache_pkg::line_u [1:0] data_in,
	input logic [31:0] wbe,
	output dcache_pkg::flag_line_t flag_out,
	output dcache_pkg::line_u [1:0] data_out
);

	localparam int SETS = 2 ** INDEX_W;
	localparam int BYTES = $bits(wbe);

	dcache_pkg::flag_line_t flag_mem [SETS];
	logic [BYTES*8-1:0] data_mem [SETS];	// both ways side by side, way 1 on top
	logic [BYTES*8-1:0] data_in_flat;

	assign data_in_flat = data_in;

	always_ff @(posedge clk_50m or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < SETS; i++) begin
				flag_mem[i] <= '0;
			end
			flag_out <= '0;
		end else if (en) begin
			if (wr_flag)
				flag_mem[index] <= flag_in;
			if (rd)
				flag_out <= flag_mem[index];	// old flags on a same-edge write
		end
	end

	always_ff @(posedge clk_50m) begin
		if (en) begin
			if (wr_data) begin
				for (int b = 0; b < BYTES; b++) begin
					if (wbe[b])
						data_mem[index][b*8 +: 8] <= data_in_flat[b*8 +: 8];
				end
			end
			if (rd)
				data_out <= data_mem[index];
		end
	end

endmodule

// ==== dcache/dcache_lookup.sv ====
`timescale 1ns/10ps

module dcache_lookup #(
	parameter int INDEX_W = dcache_pkg::INDEX_W_DEFAULT
) (
	input dcache_pkg::req_t req,
	input dcache_pkg::flag_line_t flag_out,
	input dcache_pkg::line_u [1:0] data_out,
	input dcache_pkg::line_u fill_line,
	input dcache_pkg::ctrl_state_t state,
	output logic hit,
	output logic hit_way,
	output logic evict_needed,
	output logic victim_way,
	output dcache_pkg::word_t rword,
	output dcache_pkg::flag_line_t flag_in,
	output dcache_pkg::line_u [1:0] data_in,
	output logic [31:0] wbe,
	output logic [dcache_pkg::LINE_ADDR_W-1:0] victim_addr
);

	logic [1:0] match;
	logic [1:0] free;
	logic [INDEX_W-1:0] index;
	logic [4:0] lane;	// first byte of the addressed word in wbe

	assign index = req.addr[INDEX_W+3:4];

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			match[w] = flag_out.way[w].valid && (flag_out.way[w].tag == req.addr.tag);
			free[w] = !flag_out.way[w].valid;
		end
	end

	// an empty way also counts for a write
	assign hit = (|match) || (req.wr && (|free));
	assign hit_way = !match[0] && (match[1] || !free[0]);	// real match first
	assign victim_way = !free[0] && (free[1] || flag_out.lru);
	assign evict_needed = !hit && !free[victim_way] && flag_out.way[victim_way].dirty;

	assign rword = data_out[hit_way].words[req.addr.word_off];
	assign lane = {hit_way, ~req.addr.word_off, 2'b00};

	// write-back line only while leaving CHECK, else the refill line
	assign victim_addr = (state == dcache_pkg::CHECK && evict_needed) ?
		{flag_out.way[victim_way].tag, index, 2'b00} :
		{req.addr.tag, index, 2'b00};

	always_comb begin
		flag_in = flag_out;
		data_in = data_out;
		wbe = '0;
		case (state)
			dcache_pkg::DONE: begin
				flag_in.lru = !hit_way;
				if (req.wr) begin
					flag_in.way[hit_way].valid = 1'b1;
					flag_in.way[hit_way].dirty = 1'b1;
					flag_in.way[hit_way].tag = req.addr.tag;
					data_in[hit_way].words[req.addr.word_off] = req.wdata;
					wbe[lane +: 4] = req.be;	// bytes merged in the array
				end
			end
			dcache_pkg::LOAD: begin
				flag_in.way[victim_way].valid = 1'b1;
				flag_in.way[victim_way].dirty = 1'b0;
				flag_in.way[victim_way].tag = req.addr.tag;
				data_in[victim_way] = fill_line;
				wbe[{victim_way, 4'b0000} +: 16] = '1;	// lru kept, flips in DONE
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== dcache/dcache_ctrl.sv ====
`timescale 1ns/10ps

module dcache_ctrl (
	input logic clk_50m,
	input logic rst_n,
	input logic valid,
	input dcache_pkg::req_t req,
	input logic hit,
	input logic evict_needed,
	input logic fill_done,
	output dcache_pkg::ctrl_state_t state,
	output logic en,
	output logic rd,
	output logic wr_data,
	output logic wr_flag,
	output logic mem_start,
	output logic mem_wr,
	output logic done
);

	dcache_pkg::ctrl_state_t next_state;

	always_ff @(posedge clk_50m or negedge rst_n) begin
		if (!rst_n)
			state <= dcache_pkg::IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		en = 1'b0;
		rd = 1'b0;
		wr_data = 1'b0;
		wr_flag = 1'b0;
		mem_start = 1'b0;
		mem_wr = 1'b0;
		done = 1'b0;

		case (state)
			dcache_pkg::IDLE: begin
				if (valid && (req.rd || req.wr)) begin
					en = 1'b1;	// set read, flags seen in CHECK
					rd = 1'b1;
					next_state = dcache_pkg::CHECK;
				end
			end

			dcache_pkg::CHECK: begin
				if (hit) begin
					next_state = dcache_pkg::DONE;
				end else if (evict_needed) begin
					mem_start = 1'b1;
					mem_wr = 1'b1;
					next_state = dcache_pkg::EVICT;
				end else begin
					mem_start = 1'b1;	// refill straight away
					next_state = dcache_pkg::LOAD;
				end
			end

			dcache_pkg::EVICT: begin
				// victim is out, fetch the new line
				if (fill_done) begin
					mem_start = 1'b1;
					next_state = dcache_pkg::LOAD;
				end
			end

			dcache_pkg::LOAD: begin
				if (fill_done) begin
					en = 1'b1;
					wr_data = 1'b1;
					wr_flag = 1'b1;
					next_state = dcache_pkg::LOAD2;
				end
			end

			dcache_pkg::LOAD2: begin
				en = 1'b1;	// re-read, the access now hits
				rd = 1'b1;
				next_state = dcache_pkg::DONE;
			end

			dcache_pkg::DONE: begin
				done = 1'b1;
				en = 1'b1;
				wr_data = req.wr;
				wr_flag = 1'b1;	// lru always moves
				next_state = dcache_pkg::IDLE;
			end

			default: begin
				next_state = dcache_pkg::IDLE;
			end
		endcase
	end

endmodule

// ==== rtl/line_port.sv ====
`timescale 1ns/10ps

module line_port (
	input logic clk_50m,
	input logic rst_n,
	input logic start,
	input logic wr,
	input logic [dcache_pkg::LINE_ADDR_W-1:0] line_addr,
	input dcache_pkg::line_u wline,
	input dcache_pkg::line_u mem_rline,
	input logic mem_ack,
	output dcache_pkg::mem_req_t mem_req,
	output logic mem_valid,
	output dcache_pkg::line_u fill_line,
	output logic fill_done
);

	always_ff @(posedge clk_50m or negedge rst_n) begin
		if (!rst_n) begin
			mem_valid <= 1'b0;
			fill_done <= 1'b0;
		end else begin
			fill_done <= mem_valid && mem_ack;	// write-backs finish here too
			if (start)
				mem_valid <= 1'b1;
			else if (mem_ack)
				mem_valid <= 1'b0;
		end
	end

	// request held steady until ack
	always_ff @(posedge clk_50m) begin
		if (start) begin
			mem_req.line_addr <= line_addr;
			mem_req.wr <= wr;
			mem_req.wline <= wline;
		end
		if (mem_valid && mem_ack && !mem_req.wr)
			fill_line <= mem_rline;
	end

endmodule

// ==== rtl/mem_sys.sv ====
`timescale 1ns/10ps

module mem_sys #(
	parameter int INDEX_W = dcache_pkg::INDEX_W_DEFAULT
) (
	input logic clk_50m,
	input logic rst_n,
	input logic valid,
	input dcache_pkg::req_t req,
	input dcache_pkg::line_u mem_rline,
	input logic mem_ack,
	output dcache_pkg::word_t rdata,
	output logic done,
	output dcache_pkg::mem_req_t mem_req,
	output logic mem_valid
);

	dcache_pkg::ctrl_state_t state;
	logic en, rd, wr_data, wr_flag;
	logic hit, evict_needed, victim_way;
	logic mem_start, mem_wr, fill_done;
	logic [31:0] wbe;
	logic [dcache_pkg::LINE_ADDR_W-1:0] victim_addr;
	dcache_pkg::flag_line_t flag_in, flag_out;
	dcache_pkg::line_u [1:0] data_in, data_out;
	dcache_pkg::line_u fill_line;

	dcache_ctrl u_ctrl (
		.clk_50m(clk_50m), .rst_n(rst_n), .valid(valid), .req(req),
		.hit(hit), .evict_needed(evict_needed), .fill_done(fill_done),
		.state(state), .en(en), .rd(rd), .wr_data(wr_data), .wr_flag(wr_flag),
		.mem_start(mem_start), .mem_wr(mem_wr), .done(done)
	);

	dcache_arrays #(.INDEX_W(INDEX_W)) u_arrays (
		.clk_50m(clk_50m), .rst_n(rst_n), .en(en), .rd(rd),
		.wr_data(wr_data), .wr_flag(wr_flag), .index(req.addr[INDEX_W+3:4]),
		.flag_in(flag_in), .data_in(data_in), .wbe(wbe),
		.flag_out(flag_out), .data_out(data_out)
	);

	dcache_lookup #(.INDEX_W(INDEX_W)) u_lookup (
		.req(req), .flag_out(flag_out), .data_out(data_out), .fill_line(fill_line),
		.state(state), .hit(hit), .hit_way(), .evict_needed(evict_needed),
		.victim_way(victim_way), .rword(rdata), .flag_in(flag_in), .data_in(data_in),
		.wbe(wbe), .victim_addr(victim_addr)
	);

	// victim line still on the array outputs from CHECK
	line_port u_port (
		.clk_50m(clk_50m), .rst_n(rst_n), .start(mem_start), .wr(mem_wr),
		.line_addr(victim_addr), .wline(data_out[victim_way]),
		.mem_rline(mem_rline), .mem_ack(mem_ack), .mem_req(mem_req),
		.mem_valid(mem_valid), .fill_line(fill_line), .fill_done(fill_done)
	);

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD_NS = 20,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_50m,
	output logic rst_n
);

	initial begin
		clk_50m = 1'b0;
		forever #(PERIOD_NS / 2) clk_50m = ~clk_50m;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_50m);
		#1 rst_n = 1'b1;	// released just after the edge
	end

endmodule

// ==== tests/mem_sys_tb.sv ====
`timescale 1ns/10ps

module mem_sys_tb;

	localparam int IW = dcache_pkg::INDEX_W_DEFAULT;
	localparam int TW = dcache_pkg::TAG_W;
	localparam logic [31:0] SEED = 32'h7b215896;
	localparam int N_RANDOM = 200;
	localparam int WATCHDOG_CYCLES = (N_RANDOM + 40) * 200;	// 200 cycles per request

	logic clk_50m, rst_n, valid, done, mem_valid, mem_ack;
	dcache_pkg::req_t req;
	dcache_pkg::word_t rdata;
	dcache_pkg::mem_req_t mem_req;
	dcache_pkg::line_u mem_rline;

	dcache_pkg::word_t shadow [logic [29:0]];	// word address to latest data
	logic [15:0] mem_store [logic [31:0]];	// half address to data
	logic [29:0] wb_addr_q [$];
	dcache_pkg::line_u wb_line_q [$];
	bit done_trace [$];
	logic [31:0] stim_rng, mem_rng;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clock (.clk_50m(clk_50m), .rst_n(rst_n));

	mem_sys #(.INDEX_W(IW)) u_mem_sys (
		.clk_50m(clk_50m), .rst_n(rst_n), .valid(valid), .req(req),
		.mem_rline(mem_rline), .mem_ack(mem_ack), .rdata(rdata), .done(done),
		.mem_req(mem_req), .mem_valid(mem_valid)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// complemented half address, upper bits folded in
	function automatic logic [15:0] pattern_half(input logic [31:0] haddr);
		return ~(haddr[15:0] ^ haddr[31:16]);
	endfunction

	function automatic logic [15:0] read_half(input logic [31:0] haddr);
		if (mem_store.exists(haddr))
			return mem_store[haddr];
		return pattern_half(haddr);
	endfunction

	// reference model, half 0 is the high half of a word
	function automatic dcache_pkg::word_t expected_word(input logic [29:0] waddr);
		if (shadow.exists(waddr))
			return shadow[waddr];
		return {pattern_half({1'b0, waddr, 1'b0}), pattern_half({1'b0, waddr, 1'b1})};
	endfunction

	function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old,
			input dcache_pkg::word_t wdata, input dcache_pkg::be_t be);
		dcache_pkg::word_t w;
		w = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				w[b*8 +: 8] = wdata[b*8 +: 8];
		end
		return w;
	endfunction

	function automatic dcache_pkg::line_u shadow_line(input logic [29:0] line_addr);
		dcache_pkg::line_u l;
		for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++)
			l.words[w] = expected_word({line_addr[29:2], 2'(w)});
		return l;
	endfunction

	function automatic dcache_pkg::cache_addr_t make_addr(input logic [TW-1:0] tag,
			input logic [IW-1:0] index, input logic [1:0] word_off);
		dcache_pkg::cache_addr_t a;
		a.tag = tag;
		a.index = index;
		a.word_off = word_off;
		a.byte_off = 2'b00;
		return a;
	endfunction

	task automatic check_word(input string name, input dcache_pkg::word_t exp,
			input dcache_pkg::word_t got);
		if (got !== exp) begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_line(input string name, input dcache_pkg::line_u exp,
			input dcache_pkg::line_u got);
		if (got !== exp) begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_line_addr(input string name, input logic [29:0] exp,
			input logic [29:0] got);
		if (got !== exp) begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("[ERROR] %0t %s expected %b got %b", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_wb_count(input int exp);
		if (wb_addr_q.size() != exp) begin
			$display("[ERROR] %0t writeback_count expected %0d got %0d", $time, exp,
				wb_addr_q.size());
			errors++;
		end
	endtask

	// called just after a rising edge, returns just after one
	task automatic issue(input dcache_pkg::cache_addr_t addr, input logic wr,
			input dcache_pkg::word_t wdata, input dcache_pkg::be_t be);
		req.addr = addr;
		req.wdata = wdata;
		req.be = be;
		req.rd = !wr;
		req.wr = wr;
		valid = 1'b1;
		done_trace.delete();
		do begin
			@(negedge clk_50m);
			done_trace.push_back(done);
		end while (!done);
		@(posedge clk_50m);
		#1;
		valid = 1'b0;
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: FAILED with %0d errors", name, errors - errs_before);
			tests_failed++;
		end
	endtask

	// answers each line request after 0 to 5 cycles
	initial begin : memory_model
		dcache_pkg::mem_req_t cur;
		logic [31:0] base;
		int delay;
		mem_ack = 1'b0;
		mem_rline = '0;
		mem_rng = xorshift32(SEED);
		forever begin
			@(posedge clk_50m);
			#1;
			if (mem_valid) begin
				cur = mem_req;
				base = {1'b0, cur.line_addr, 1'b0};
				mem_rng = xorshift32(mem_rng);
				delay = int'(mem_rng % 32'd6);
				repeat (delay) begin
					@(posedge clk_50m);
					#1;
				end
				for (int h = 0; h < dcache_pkg::HALVES_PER_LINE; h++) begin
					if (cur.wr)
						mem_store[base + 32'(h)] = cur.wline.halves[h];
					else
						mem_rline.halves[h] = read_half(base + 32'(h));
				end
				if (cur.wr) begin
					wb_addr_q.push_back(cur.line_addr);	// write-back log
					wb_line_q.push_back(cur.wline);
				end
				mem_ack = 1'b1;
				@(posedge clk_50m);
				#1;
				mem_ack = 1'b0;
			end
		end
	end

	always @(negedge clk_50m) begin
		if (rst_n && done) begin
			if (req.rd)
				check_word("rdata", expected_word(req.addr[31:2]), rdata);
			if (req.wr)
				shadow[req.addr[31:2]] =
					merge_bytes(expected_word(req.addr[31:2]), req.wdata, req.be);
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_50m);
		$display("watchdog expired after %0d cycles, a request never finished",
			WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin : stimulus
		dcache_pkg::cache_addr_t a;
		logic [31:0] r;
		int mark;
		valid = 1'b0;
		req = '0;
		stim_rng = SEED;
		wait (rst_n);
		@(posedge clk_50m);
		#1;

		mark = errors;
		issue(make_addr(TW'(3), IW'(1), 2'd2), 1'b0, '0, '0);
		end_test("read_miss", mark);

		mark = errors;
		a = make_addr(TW'(5), IW'(2), 2'd1);
		issue(a, 1'b0, '0, '0);	// line brought in first
		issue(a, 1'b1, 32'ha5c3_96e1, 4'b0101);
		issue(a, 1'b0, '0, '0);
		end_test("write_then_read", mark);

		mark = errors;
		issue(make_addr(TW'(3), IW'(1), 2'd2), 1'b0, '0, '0);
		check_flag("done(accept+1)", 1'b0, done_trace[1]);
		check_flag("done(accept+2)", 1'b1, done_trace[2]);
		end_test("hit_latency", mark);

		mark = errors;
		wb_addr_q.delete();
		wb_line_q.delete();
		a = make_addr(TW'(7), IW'(4), 2'd0);
		issue(a, 1'b0, '0, '0);
		issue(a, 1'b1, 32'h1234_5678, 4'b1111);
		issue(make_addr(TW'(7), IW'(4), 2'd2), 1'b1, 32'hdead_beef, 4'b1100);
		issue(make_addr(TW'(8), IW'(4), 2'd0), 1'b0, '0, '0);
		issue(make_addr(TW'(9), IW'(4), 2'd3), 1'b0, '0, '0);	// evicts dirty A
		issue(make_addr(TW'(7), IW'(4), 2'd2), 1'b0, '0, '0);	// refetched from memory
		check_wb_count(1);
		if (wb_addr_q.size() == 1) begin
			check_line_addr("mem_req.line_addr", {a.tag, a.index, 2'b00}, wb_addr_q[0]);
			check_line("mem_req.wline", shadow_line({a.tag, a.index, 2'b00}), wb_line_q[0]);
		end
		end_test("dirty_eviction", mark);

		mark = errors;
		wb_addr_q.delete();
		wb_line_q.delete();
		for (int t = 1; t <= 5; t++)
			issue(make_addr(TW'(t % 4 + 1), IW'(5), 2'd1), 1'b0, '0, '0);
		check_wb_count(0);
		end_test("clean_victims", mark);

		mark = errors;
		for (int i = 0; i < 4; i++) begin
			issue(make_addr(TW'(1), IW'(8 + i), 2'd0), 1'b0, '0, '0);	// fill both ways
			issue(make_addr(TW'(2), IW'(8 + i), 2'd0), 1'b0, '0, '0);
		end
		repeat (N_RANDOM) begin
			stim_rng = xorshift32(stim_rng);
			r = stim_rng;
			issue(make_addr(TW'(1 + r[3:2]), IW'(8 + r[1:0]), r[5:4]), r[6],
				xorshift32(r), r[10:7]);
		end
		end_test("random_mix", mark);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== files.f ====
common/dcache_pkg.sv
dcache/dcache_arrays.sv
dcache/dcache_lookup.sv
dcache/dcache_ctrl.sv
rtl/line_port.sv
rtl/mem_sys.sv
tests/tb_clock.sv
tests/mem_sys_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = mem_sys_tb
FILELIST   = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
